//--- src/seg_pkg.sv
// Shared sizes and types for the segment register file.
package seg_pkg;

    // Six segment registers in the order ES, CS, SS, DS, FS, GS.
    localparam int num_slots = 6;

    // Load, destination and read ports all come in groups of this size.
    localparam int num_ports = 4;

    // Selector width. Codes 6 and 7 do not address a register.
    localparam int sel_w = 3;

    localparam int base_w = 16; // Base selector.
    localparam int lim_w = 20;  // Segment limit.
    localparam int tag_w = 7;   // Producer tag of the rename record.

    typedef logic [sel_w-1:0] slot_sel_t;

    // Everything one register holds, 44 bits in all.
    typedef struct packed {
        logic [base_w-1:0] base;
        logic [lim_w-1:0]  lim;
        logic [tag_w-1:0]  tag;
        logic              pending; // Set while the producer has not written back.
    } seg_state_t;

endpackage

//--- src/seg_slot_if.sv
`timescale 1ns/100ps

// Write controls into one segment register and its stored state coming back.
interface seg_slot_if;

    logic                         ld;      // Load base and limit this cycle.
    logic [seg_pkg::base_w-1:0]   base_wr;
    logic [seg_pkg::lim_w-1:0]    lim_wr;
    logic                         mark;    // Rename the register to new_tag.
    logic [seg_pkg::tag_w-1:0]    new_tag;
    logic                         clr;
    logic                         flush;
    seg_pkg::seg_state_t          state;

    modport ctrl (
        output ld, base_wr, lim_wr,
        output mark, new_tag,
        output clr, flush
    );

    modport slot (
        input  ld, base_wr, lim_wr,
        input  mark, new_tag,
        input  clr, flush,
        output state
    );

    modport reader (
        input state
    );

endinterface

//--- src/seg_ctrl.sv
`timescale 1ns/100ps

// Port decode and priority for the segment register file. Everything here is
// combinational, so each strobe lands in the slots at the edge that samples it.
module seg_ctrl (
    input  logic [seg_pkg::num_ports-1:0] ld_en,
    input  seg_pkg::slot_sel_t            ld_sel [seg_pkg::num_ports],
    input  logic [seg_pkg::base_w-1:0]    base_in [seg_pkg::num_ports],
    input  logic [seg_pkg::lim_w-1:0]     lim_in [seg_pkg::num_ports],
    input  logic [seg_pkg::num_ports-1:0] dest,
    input  seg_pkg::slot_sel_t            dest_sel [seg_pkg::num_ports],
    input  logic [seg_pkg::tag_w-1:0]     new_tag,
    input  logic                          clr,
    input  logic                          flush,
    seg_slot_if.ctrl                      slots [seg_pkg::num_slots]
);

    // One-hot slot vectors per port, already gated with the port's strobe.
    logic [seg_pkg::num_slots-1:0] ld_hot [seg_pkg::num_ports];
    logic [seg_pkg::num_slots-1:0] dest_hot [seg_pkg::num_ports];

    // Selector codes past the last slot give an all-zero vector.
    function automatic logic [seg_pkg::num_slots-1:0] decode_sel(
        input seg_pkg::slot_sel_t sel,
        input logic               en
    );
        logic [seg_pkg::num_slots-1:0] hot;
        hot = '0;
        for (int s = 0; s < seg_pkg::num_slots; s++) begin
            if (en && int'(sel) == s) begin
                hot[s] = 1'b1;
            end
        end
        return hot;
    endfunction

    for (genvar k = 0; k < seg_pkg::num_ports; k++) begin : g_port
        assign ld_hot[k]   = decode_sel(ld_sel[k], ld_en[k]);
        assign dest_hot[k] = decode_sel(dest_sel[k], dest[k]);
    end

    for (genvar s = 0; s < seg_pkg::num_slots; s++) begin : g_slot
        logic [seg_pkg::base_w-1:0] base_pick;
        logic [seg_pkg::lim_w-1:0]  lim_pick;
        logic                       any_ld;
        logic                       any_mark;

        // Ports are scanned upward, so the highest loading port wins.
        always_comb begin
            base_pick = '0;
            lim_pick  = '0;
            any_ld    = 1'b0;
            any_mark  = 1'b0;
            for (int k = 0; k < seg_pkg::num_ports; k++) begin
                if (ld_hot[k][s]) begin
                    base_pick = base_in[k];
                    lim_pick  = lim_in[k];
                    any_ld    = 1'b1;
                end
                if (dest_hot[k][s]) begin
                    any_mark = 1'b1; // Any destination port may rename the slot.
                end
            end
        end

        assign slots[s].ld      = any_ld;
        assign slots[s].base_wr = base_pick;
        assign slots[s].lim_wr  = lim_pick;
        assign slots[s].mark    = any_mark;
        assign slots[s].new_tag = new_tag; // Every marked slot takes the same tag.

        // Clear and flush go to all slots alike.
        assign slots[s].clr   = clr;
        assign slots[s].flush = flush;
    end

endmodule

//--- src/seg_slot.sv
`timescale 1ns/100ps

// One segment register with its rename record.
module seg_slot (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      wb_valid,
    input  logic [seg_pkg::tag_w-1:0] wb_tag,
    seg_slot_if.slot                  slot
);

    logic [seg_pkg::base_w-1:0] base_q;
    logic [seg_pkg::lim_w-1:0]  lim_q;
    logic [seg_pkg::tag_w-1:0]  tag_q;
    logic                       pending_q;
    logic                       tag_hit;

    // The broadcast producer matches the one this register waits on.
    assign tag_hit = wb_valid && (tag_q == wb_tag);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            base_q <= '0;
            lim_q  <= '0;
        end else if (slot.clr) begin
            base_q <= '0;
            lim_q  <= '0;
        end else if (slot.ld) begin
            base_q <= slot.base_wr;
            lim_q  <= slot.lim_wr;
        end
    end

    // Clear first, then a new mark, then anything that drops pending.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tag_q     <= '0;
            pending_q <= 1'b0;
        end else if (slot.clr) begin
            tag_q     <= '0;
            pending_q <= 1'b0;
        end else if (slot.mark) begin
            tag_q     <= slot.new_tag;
            pending_q <= 1'b1;
        end else if (slot.flush || tag_hit) begin
            pending_q <= 1'b0; // The tag stays for later inspection.
        end
    end

    assign slot.state.base    = base_q;
    assign slot.state.lim     = lim_q;
    assign slot.state.tag     = tag_q;
    assign slot.state.pending = pending_q;

endmodule

//--- src/seg_read_port.sv
`timescale 1ns/100ps

// Six-way read selector. The payload type is a parameter so that the same
// selector can serve a whole state record or any single field of it.
module seg_read_port #(
    parameter type payload_t = seg_pkg::seg_state_t
) (
    input  payload_t           entries [seg_pkg::num_slots],
    input  seg_pkg::slot_sel_t sel,
    output payload_t           q
);

    // An unused selector code matches no slot and reads as zero.
    always_comb begin
        q = '0;
        for (int s = 0; s < seg_pkg::num_slots; s++) begin
            if (int'(sel) == s) begin
                q = entries[s];
            end
        end
    end

endmodule

//--- src/seg_regfile.sv
`timescale 1ns/100ps

// Segment register file of the decode and rename stage.
module seg_regfile (
    input  logic                          clk,
    input  logic                          arst_n,

    // Load ports write base and limit.
    input  logic [seg_pkg::num_ports-1:0] ld_en,
    input  seg_pkg::slot_sel_t            ld_sel [seg_pkg::num_ports],
    input  logic [seg_pkg::base_w-1:0]    base_in [seg_pkg::num_ports],
    input  logic [seg_pkg::lim_w-1:0]     lim_in [seg_pkg::num_ports],

    // Destination ports rename a register to the new producer.
    input  logic [seg_pkg::num_ports-1:0] dest,
    input  seg_pkg::slot_sel_t            dest_sel [seg_pkg::num_ports],
    input  logic [seg_pkg::tag_w-1:0]     new_tag,

    input  logic                          wb_valid,
    input  logic [seg_pkg::tag_w-1:0]     wb_tag,
    input  logic                          clr,
    input  logic                          flush,

    input  seg_pkg::slot_sel_t            rd_sel [seg_pkg::num_ports],
    output logic [seg_pkg::base_w-1:0]    rd_base [seg_pkg::num_ports],
    output logic [seg_pkg::lim_w-1:0]     rd_lim [seg_pkg::num_ports],
    output logic [seg_pkg::tag_w-1:0]     rd_tag [seg_pkg::num_ports],
    output logic                          rd_pending [seg_pkg::num_ports]
);

    seg_slot_if slot_if [seg_pkg::num_slots] ();

    seg_pkg::seg_state_t states [seg_pkg::num_slots];
    seg_pkg::seg_state_t rd_q [seg_pkg::num_ports];

    seg_ctrl i_seg_ctrl (
        .ld_en    (ld_en),
        .ld_sel   (ld_sel),
        .base_in  (base_in),
        .lim_in   (lim_in),
        .dest     (dest),
        .dest_sel (dest_sel),
        .new_tag  (new_tag),
        .clr      (clr),
        .flush    (flush),
        .slots    (slot_if)
    );

    // Slot index follows the ES, CS, SS, DS, FS, GS order.
    for (genvar s = 0; s < seg_pkg::num_slots; s++) begin : g_slot
        seg_slot i_seg_slot (
            .clk      (clk),
            .arst_n   (arst_n),
            .wb_valid (wb_valid),
            .wb_tag   (wb_tag),
            .slot     (slot_if[s])
        );

        assign states[s] = slot_if[s].state;
    end

    // Reads see the stored state, so a write shows up one cycle after its strobe.
    for (genvar p = 0; p < seg_pkg::num_ports; p++) begin : g_rd
        seg_read_port #(
            .payload_t (seg_pkg::seg_state_t)
        ) i_seg_read_port (
            .entries (states),
            .sel     (rd_sel[p]),
            .q       (rd_q[p])
        );

        assign rd_base[p]    = rd_q[p].base;
        assign rd_lim[p]     = rd_q[p].lim;
        assign rd_tag[p]     = rd_q[p].tag;
        assign rd_pending[p] = rd_q[p].pending;
    end

endmodule

//--- test/seg_regfile_properties.sv
`timescale 1ns/100ps

// Concurrent checks on one segment register, bound into every seg_slot.
module seg_regfile_properties (
    input logic                       clk,
    input logic                       arst_n,
    input logic                       clr,
    input logic                       mark,
    input logic [seg_pkg::tag_w-1:0]  new_tag,
    input logic [seg_pkg::base_w-1:0] base,
    input logic [seg_pkg::lim_w-1:0]  lim,
    input logic [seg_pkg::tag_w-1:0]  tag,
    input logic                       pending
);

    // A register only becomes pending through a rename.
    pending_needs_mark: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(pending) |-> $past(mark)
    ) else $error("pending bit rose without a mark in the cycle before");

    clr_zeroes_state: assert property (
        @(posedge clk) disable iff (!arst_n)
        clr |=> (base == '0 && lim == '0 && tag == '0 && !pending)
    ) else $error("register state not zero one cycle after clr");

    // A mark without clr leaves the register pending under the new tag.
    mark_sets_record: assert property (
        @(posedge clk) disable iff (!arst_n)
        (mark && !clr) |=> (pending && tag == $past(new_tag))
    ) else $error("mark did not leave the register pending with the new tag");

    tag_holds: assert property (
        @(posedge clk) disable iff (!arst_n)
        (!mark && !clr) |=> (tag == $past(tag))
    ) else $error("tag changed without a mark or clr");

endmodule

bind seg_slot seg_regfile_properties i_seg_regfile_properties (
    .clk     (clk),
    .arst_n  (arst_n),
    .clr     (slot.clr),
    .mark    (slot.mark),
    .new_tag (slot.new_tag),
    .base    (base_q),
    .lim     (lim_q),
    .tag     (tag_q),
    .pending (pending_q)
);

//--- test/seg_regfile_tb.sv
`timescale 1ns/100ps

// Testbench for the segment register file. A directed table runs first, then
// random steps that a behavioral model of the six registers checks.
module seg_regfile_tb;

    localparam int clk_period = 4;
    localparam int n_table    = 12;
    localparam int n_random   = 300;
    localparam int margin_ns  = 200;

    typedef logic [seg_pkg::base_w-1:0]    base_t;
    typedef logic [seg_pkg::lim_w-1:0]     lim_t;
    typedef logic [seg_pkg::tag_w-1:0]     tag_t;
    typedef logic [seg_pkg::num_ports-1:0] port_vec_t;

    // One cycle of stimulus and the reads expected after its clock edge.
    typedef struct packed {
        port_vec_t                                    ld_en;
        seg_pkg::slot_sel_t [seg_pkg::num_ports-1:0]  ld_sel;
        base_t [seg_pkg::num_ports-1:0]               base;
        lim_t [seg_pkg::num_ports-1:0]                lim;
        port_vec_t                                    dest;
        seg_pkg::slot_sel_t [seg_pkg::num_ports-1:0]  dest_sel;
        tag_t                                         new_tag;
        logic                                         wb_valid;
        tag_t                                         wb_tag;
        logic                                         clr;
        logic                                         flush;
        seg_pkg::slot_sel_t [seg_pkg::num_ports-1:0]  rd_sel;
        seg_pkg::seg_state_t [seg_pkg::num_ports-1:0] exp;
    } step_t;

    logic                clk;
    logic                arst_n;
    port_vec_t           ld_en;
    seg_pkg::slot_sel_t  ld_sel [seg_pkg::num_ports];
    base_t               base_in [seg_pkg::num_ports];
    lim_t                lim_in [seg_pkg::num_ports];
    port_vec_t           dest;
    seg_pkg::slot_sel_t  dest_sel [seg_pkg::num_ports];
    tag_t                new_tag;
    logic                wb_valid;
    tag_t                wb_tag;
    logic                clr;
    logic                flush;
    seg_pkg::slot_sel_t  rd_sel [seg_pkg::num_ports];
    base_t               rd_base [seg_pkg::num_ports];
    lim_t                rd_lim [seg_pkg::num_ports];
    tag_t                rd_tag [seg_pkg::num_ports];
    logic                rd_pending [seg_pkg::num_ports];

    step_t               steps [n_table];
    step_t               cur;
    int                  n_built;
    int                  errors;
    seg_pkg::seg_state_t model [seg_pkg::num_slots]; // Reference copy of the registers.

    seg_regfile i_seg_regfile (
        .clk        (clk),
        .arst_n     (arst_n),
        .ld_en      (ld_en),
        .ld_sel     (ld_sel),
        .base_in    (base_in),
        .lim_in     (lim_in),
        .dest       (dest),
        .dest_sel   (dest_sel),
        .new_tag    (new_tag),
        .wb_valid   (wb_valid),
        .wb_tag     (wb_tag),
        .clr        (clr),
        .flush      (flush),
        .rd_sel     (rd_sel),
        .rd_base    (rd_base),
        .rd_lim     (rd_lim),
        .rd_tag     (rd_tag),
        .rd_pending (rd_pending)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    initial begin
        #((n_table + n_random + 2) * clk_period + margin_ns);
        $display("Timeout: the run did not finish within %0d ns.",
                 (n_table + n_random + 2) * clk_period + margin_ns);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    task automatic fail_check(string msg);
        errors++;
        $display("Mismatch at time %0t: %s", $time, msg);
        $display("test failed");
        $fatal(1, "stopping at the first mismatch");
    endtask

    // Every port reads the unused code 7 unless a step says otherwise.
    task automatic start_step();
        cur = '0;
        for (int p = 0; p < seg_pkg::num_ports; p++) begin
            cur.rd_sel[p] = 3'd7;
        end
    endtask

    task automatic load_port(int k, int sel, base_t b, lim_t l);
        cur.ld_en[k]  = 1'b1;
        cur.ld_sel[k] = seg_pkg::slot_sel_t'(sel);
        cur.base[k]   = b;
        cur.lim[k]    = l;
    endtask

    task automatic mark_port(int k, int sel);
        cur.dest[k]     = 1'b1;
        cur.dest_sel[k] = seg_pkg::slot_sel_t'(sel);
    endtask

    task automatic expect_read(int p, int sel, base_t b, lim_t l, tag_t t, logic pend);
        cur.rd_sel[p]         = seg_pkg::slot_sel_t'(sel);
        cur.exp[p].base    = b;
        cur.exp[p].lim     = l;
        cur.exp[p].tag     = t;
        cur.exp[p].pending = pend;
    endtask

    task automatic commit_step();
        if (n_built < n_table) begin
            steps[n_built] = cur;
        end
        n_built++;
    endtask

    // Slots are ES 0, CS 1, SS 2, DS 3, FS 4, GS 5.
    task automatic build_table();
        start_step(); // Reset leaves everything at zero.
        for (int p = 0; p < 4; p++) expect_read(p, p, '0, '0, '0, 1'b0);
        commit_step();
        start_step(); // Plain loads, plus two loads to unused codes.
        load_port(0, 1, 16'h1111, 20'h11111);
        load_port(1, 3, 16'h3333, 20'h33333);
        load_port(2, 6, 16'hdead, 20'hbeef0);
        load_port(3, 7, 16'hffff, 20'hfffff);
        expect_read(0, 1, 16'h1111, 20'h11111, '0, 1'b0);
        expect_read(1, 3, 16'h3333, 20'h33333, '0, 1'b0);
        expect_read(2, 6, '0, '0, '0, 1'b0);
        expect_read(3, 7, '0, '0, '0, 1'b0);
        commit_step();
        start_step(); // Ports 1 and 3 both load SS, port 3 wins.
        load_port(0, 0, 16'h0e0e, 20'h0e0e0);
        load_port(1, 2, 16'h2222, 20'h22222);
        load_port(3, 2, 16'h2aaa, 20'h2aaaa);
        expect_read(0, 2, 16'h2aaa, 20'h2aaaa, '0, 1'b0);
        expect_read(1, 0, 16'h0e0e, 20'h0e0e0, '0, 1'b0);
        expect_read(2, 4, '0, '0, '0, 1'b0);
        expect_read(3, 5, '0, '0, '0, 1'b0);
        commit_step();
        start_step();
        load_port(0, 5, 16'h5000, 20'h50000);
        load_port(2, 5, 16'h5555, 20'h55555);
        expect_read(0, 5, 16'h5555, 20'h55555, '0, 1'b0);
        expect_read(1, 1, 16'h1111, 20'h11111, '0, 1'b0);
        expect_read(2, 3, 16'h3333, 20'h33333, '0, 1'b0);
        expect_read(3, 2, 16'h2aaa, 20'h2aaaa, '0, 1'b0);
        commit_step();
        start_step(); // Two slots renamed to one tag, a third mark hits code 6.
        cur.new_tag = 7'h21;
        mark_port(0, 1);
        mark_port(2, 3);
        mark_port(3, 6);
        expect_read(0, 1, 16'h1111, 20'h11111, 7'h21, 1'b1);
        expect_read(1, 3, 16'h3333, 20'h33333, 7'h21, 1'b1);
        expect_read(2, 0, 16'h0e0e, 20'h0e0e0, '0, 1'b0);
        expect_read(3, 6, '0, '0, '0, 1'b0);
        commit_step();
        start_step();
        cur.new_tag = 7'h35;
        mark_port(1, 5);
        expect_read(0, 5, 16'h5555, 20'h55555, 7'h35, 1'b1);
        expect_read(1, 1, 16'h1111, 20'h11111, 7'h21, 1'b1);
        expect_read(2, 2, 16'h2aaa, 20'h2aaaa, '0, 1'b0);
        expect_read(3, 3, 16'h3333, 20'h33333, 7'h21, 1'b1);
        commit_step();
        start_step(); // Writeback of 21 while DS is renamed again.
        cur.wb_valid = 1'b1;
        cur.wb_tag   = 7'h21;
        cur.new_tag  = 7'h44;
        mark_port(0, 3);
        expect_read(0, 1, 16'h1111, 20'h11111, 7'h21, 1'b0);
        expect_read(1, 3, 16'h3333, 20'h33333, 7'h44, 1'b1);
        expect_read(2, 5, 16'h5555, 20'h55555, 7'h35, 1'b1);
        expect_read(3, 0, 16'h0e0e, 20'h0e0e0, '0, 1'b0);
        commit_step();
        start_step(); // A writeback that matches nothing.
        cur.wb_valid = 1'b1;
        cur.wb_tag   = 7'h22;
        cur.new_tag  = 7'h10;
        mark_port(3, 0);
        mark_port(1, 2);
        expect_read(0, 0, 16'h0e0e, 20'h0e0e0, 7'h10, 1'b1);
        expect_read(1, 2, 16'h2aaa, 20'h2aaaa, 7'h10, 1'b1);
        expect_read(2, 3, 16'h3333, 20'h33333, 7'h44, 1'b1);
        expect_read(3, 5, 16'h5555, 20'h55555, 7'h35, 1'b1);
        commit_step();
        start_step(); // Flush keeps the tags, the mark on FS survives it.
        cur.flush   = 1'b1;
        cur.new_tag = 7'h66;
        mark_port(2, 4);
        expect_read(0, 0, 16'h0e0e, 20'h0e0e0, 7'h10, 1'b0);
        expect_read(1, 3, 16'h3333, 20'h33333, 7'h44, 1'b0);
        expect_read(2, 5, 16'h5555, 20'h55555, 7'h35, 1'b0);
        expect_read(3, 4, '0, '0, 7'h66, 1'b1);
        commit_step();
        start_step();
        expect_read(0, 2, 16'h2aaa, 20'h2aaaa, 7'h10, 1'b0);
        expect_read(1, 1, 16'h1111, 20'h11111, 7'h21, 1'b0);
        expect_read(2, 4, '0, '0, 7'h66, 1'b1);
        expect_read(3, 6, '0, '0, '0, 1'b0);
        commit_step();
        start_step(); // Clear beats a load and a mark in the same cycle.
        cur.clr     = 1'b1;
        cur.new_tag = 7'h12;
        load_port(0, 1, 16'h7777, 20'h77777);
        mark_port(0, 1);
        for (int p = 0; p < 4; p++) expect_read(p, p, '0, '0, '0, 1'b0);
        commit_step();
        start_step();
        for (int p = 0; p < 4; p++) expect_read(p, (p + 4) % 6, '0, '0, '0, 1'b0);
        commit_step();
    endtask

    task automatic drive_inputs(step_t st);
        ld_en    = st.ld_en;
        dest     = st.dest;
        new_tag  = st.new_tag;
        wb_valid = st.wb_valid;
        wb_tag   = st.wb_tag;
        clr      = st.clr;
        flush    = st.flush;
        for (int k = 0; k < seg_pkg::num_ports; k++) begin
            ld_sel[k]   = st.ld_sel[k];
            base_in[k]  = st.base[k];
            lim_in[k]   = st.lim[k];
            dest_sel[k] = st.dest_sel[k];
            rd_sel[k]   = st.rd_sel[k];
        end
    endtask

    // Applies one step to the reference registers as the write rules describe it.
    task automatic model_update(step_t st);
        logic marked;
        for (int s = 0; s < seg_pkg::num_slots; s++) begin
            marked = 1'b0;
            for (int k = 0; k < seg_pkg::num_ports; k++) begin
                if (st.ld_en[k] && int'(st.ld_sel[k]) == s) begin
                    model[s].base = st.base[k];
                    model[s].lim  = st.lim[k];
                end
                if (st.dest[k] && int'(st.dest_sel[k]) == s) begin
                    marked = 1'b1;
                end
            end
            if (st.clr) begin
                model[s] = '0;
            end else if (marked) begin
                model[s].tag     = st.new_tag;
                model[s].pending = 1'b1;
            end else if (st.flush || (st.wb_valid && model[s].tag == st.wb_tag)) begin
                model[s].pending = 1'b0;
            end
        end
    endtask

    function automatic step_t with_model_reads(step_t st);
        for (int p = 0; p < seg_pkg::num_ports; p++) begin
            st.exp[p] = '0;
            for (int s = 0; s < seg_pkg::num_slots; s++) begin
                if (int'(st.rd_sel[p]) == s) st.exp[p] = model[s];
            end
        end
        return st;
    endfunction

    // Few distinct tags, so that writebacks hit stored tags often.
    function automatic step_t random_step();
        step_t st;
        st = '0;
        for (int k = 0; k < seg_pkg::num_ports; k++) begin
            st.ld_en[k]    = ($urandom_range(2, 0) == 0);
            st.ld_sel[k]   = seg_pkg::slot_sel_t'($urandom_range(7, 0));
            st.base[k]     = base_t'($urandom);
            st.lim[k]      = lim_t'($urandom);
            st.dest[k]     = ($urandom_range(3, 0) == 0);
            st.dest_sel[k] = seg_pkg::slot_sel_t'($urandom_range(7, 0));
            st.rd_sel[k]   = seg_pkg::slot_sel_t'($urandom_range(7, 0));
        end
        st.new_tag  = tag_t'($urandom_range(7, 0));
        st.wb_valid = ($urandom_range(1, 0) == 1);
        st.wb_tag   = tag_t'($urandom_range(7, 0));
        st.flush    = ($urandom_range(15, 0) == 0);
        st.clr      = ($urandom_range(31, 0) == 0);
        return st;
    endfunction

    task automatic check_reads(step_t st, int idx, string phase);
        seg_pkg::seg_state_t got;
        string               msg;
        for (int p = 0; p < seg_pkg::num_ports; p++) begin
            got.base    = rd_base[p];
            got.lim     = rd_lim[p];
            got.tag     = rd_tag[p];
            got.pending = rd_pending[p];
            assert (got == st.exp[p]) else begin
                msg = $sformatf("%s step %0d, read port %0d, sel %0d:",
                                phase, idx, p, st.rd_sel[p]);
                msg = {msg, $sformatf(" got base %h lim %h tag %h pending %b,",
                                      got.base, got.lim, got.tag, got.pending)};
                msg = {msg, $sformatf(" expected base %h lim %h tag %h pending %b",
                                      st.exp[p].base, st.exp[p].lim, st.exp[p].tag,
                                      st.exp[p].pending)};
                fail_check(msg);
            end
        end
    endtask

    initial begin
        step_t st;
        arst_n = 1'b0;
        errors = 0;
        n_built = 0;
        st = '0;
        drive_inputs(st);
        void'($urandom(6));
        for (int s = 0; s < seg_pkg::num_slots; s++) model[s] = '0;
        build_table();
        assert (n_built == n_table) else begin
            $display("The stimulus table holds %0d steps instead of %0d.", n_built, n_table);
            $display("test failed");
            $fatal(1, "bad stimulus table");
        end
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < n_table; i++) begin
            drive_inputs(steps[i]);
            model_update(steps[i]);
            @(negedge clk);
            check_reads(steps[i], i, "table");
        end
        for (int i = 0; i < n_random; i++) begin
            st = random_step();
            drive_inputs(st);
            model_update(st);
            st = with_model_reads(st);
            @(negedge clk);
            check_reads(st, i, "random");
        end
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- tb.f
src/seg_pkg.sv
src/seg_slot_if.sv
src/seg_ctrl.sv
src/seg_slot.sv
src/seg_read_port.sv
src/seg_regfile.sv
test/seg_regfile_properties.sv
test/seg_regfile_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for a failure.
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f tb.f --top-module seg_regfile_tb -o seg_regfile_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/seg_regfile_sim > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0
